//--- dcache.f
dcache_pkg.sv
dcache_way.sv
dcache_read_mux.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

//--- dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
   import dcache_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   // processor request
   input  logic     i_read,
   input  logic     i_write,
   input  addr_t    i_addr,
   input  be_t      i_be,
   input  word_t    i_wdata,

   // lookup result from the read mux
   input  logic     i_hit,
   input  way_vec_t i_hit_way,
   input  logic     i_victim_dirty,
   input  tag_t     i_victim_tag,

   // memory bus inputs
   input  logic     i_arready,
   input  word_t    i_rdata,
   input  logic     i_rvalid,
   input  logic     i_rlast,
   input  logic     i_awready,
   input  logic     i_wready,
   input  logic     i_bvalid,

   output logic     o_stall,

   // way control
   output index_t   o_index,
   output tag_t     o_tag,
   output woff_t    o_woff,
   output word_t    o_way_wdata,
   output be_t      o_way_be [NUM_WAYS],
   output way_vec_t o_install,
   output way_vec_t o_mark_dirty,
   output way_vec_t o_victim,

   // memory bus outputs
   output addr_t    o_araddr,
   output logic     o_arvalid,
   output addr_t    o_awaddr,
   output logic     o_awvalid,
   output logic     o_wvalid,
   output logic     o_wlast
);

   cache_state_e        state_r;
   woff_t               beat_cnt;
   logic [NUM_SETS-1:0] lru_r;

   logic  req;
   logic  idle_hit;
   addr_t req_line;
   addr_t victim_line;

   ////////////////////
   // request decode
   ////////////////////

   assign req      = i_read || i_write;
   assign idle_hit = (state_r == IDLE) && req && i_hit;

   assign o_tag   = i_addr[31 -: TAG_W];
   assign o_index = i_addr[LINE_OFF_W +: INDEX_W];

   // burst beats walk the line from offset zero
   assign o_woff = (state_r == IDLE) ? i_addr[BYTE_OFF_W +: OFFSET_W] : beat_cnt;

   assign req_line    = {o_tag, o_index, {LINE_OFF_W{1'b0}}};
   assign victim_line = {i_victim_tag, o_index, {LINE_OFF_W{1'b0}}};

   // stall on a miss and for the whole miss sequence
   assign o_stall = req && ((state_r != IDLE) || !i_hit);

   // lru bit names the way to replace next
   assign o_victim = lru_r[o_index] ? 2'b10 : 2'b01;

   ////////////////////
   // way write control
   ////////////////////

   assign o_way_wdata = (state_r == RF_DATA) ? i_rdata : i_wdata;

   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         if ((state_r == RF_DATA) && i_rvalid && o_victim[w]) begin
            o_way_be[w] = 4'hf;
         end else if (idle_hit && i_write && i_hit_way[w]) begin
            o_way_be[w] = i_be;
         end else begin
            o_way_be[w] = '0;
         end
      end
   end

   assign o_install    = (state_r == INSTALL) ? o_victim : '0;
   assign o_mark_dirty = (idle_hit && i_write) ? i_hit_way : '0;

   // point away from the way just used
   always_ff @(posedge clk) begin
      if (reset) begin
         lru_r <= '0;
      end else if (idle_hit) begin
         lru_r[o_index] <= i_hit_way[0];
      end else if (state_r == INSTALL) begin
         lru_r[o_index] <= o_victim[0];
      end
   end

   ////////////////////
   // miss FSM
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state_r   <= IDLE;
         beat_cnt  <= '0;
         o_arvalid <= 1'b0;
         o_awvalid <= 1'b0;
         o_wvalid  <= 1'b0;
         o_wlast   <= 1'b0;
      end else begin
         case (state_r)
            IDLE: begin
               if (req && !i_hit) begin
                  beat_cnt <= '0;
                  if (i_victim_dirty) begin
                     o_awvalid <= 1'b1;
                     state_r   <= WB_ADDR;
                  end else begin
                     o_arvalid <= 1'b1;
                     state_r   <= RF_ADDR;
                  end
               end
            end
            WB_ADDR: begin
               if (i_awready) begin
                  o_awvalid <= 1'b0;
                  o_wvalid  <= 1'b1;
                  state_r   <= WB_DATA;
               end
            end
            WB_DATA: begin
               if (i_wready) begin
                  if (o_wlast) begin
                     o_wvalid <= 1'b0;
                     o_wlast  <= 1'b0;
                     beat_cnt <= '0;
                     state_r  <= WB_RESP;
                  end else begin
                     beat_cnt <= beat_cnt + woff_t'(1);
                     o_wlast  <= (beat_cnt + woff_t'(1) == LAST_BEAT);
                  end
               end
            end
            WB_RESP: begin
               if (i_bvalid) begin
                  o_arvalid <= 1'b1;
                  state_r   <= RF_ADDR;
               end
            end
            RF_ADDR: begin
               if (i_arready) begin
                  o_arvalid <= 1'b0;
                  beat_cnt  <= '0;
                  state_r   <= RF_DATA;
               end
            end
            RF_DATA: begin
               if (i_rvalid) begin
                  beat_cnt <= beat_cnt + woff_t'(1);
                  if (i_rlast) begin
                     state_r <= INSTALL;
                  end
               end
            end
            INSTALL: begin
               state_r <= IDLE;
            end
            default: begin
               state_r <= IDLE;
            end
         endcase
      end
   end

   // burst addresses, captured when the channel is opened
   always_ff @(posedge clk) begin
      if ((state_r == IDLE) && req && !i_hit) begin
         o_awaddr <= victim_line;
         o_araddr <= req_line;
      end
   end

   ////////////////////
   // checks
   ////////////////////

   a_one_channel : assert property (
      @(posedge clk) disable iff (reset)
      !(o_arvalid && o_awvalid)
   ) else $error("read and write address valid together");

   // address must hold until the memory takes it
   a_ar_hold : assert property (
      @(posedge clk) disable iff (reset)
      (o_arvalid && !i_arready) |=> (o_arvalid && $stable(o_araddr))
   ) else $error("read address dropped before arready");

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

   ////////////////////
   // cache geometry
   ////////////////////

   // two ways, 32-byte lines, 128 sets
   localparam int NUM_WAYS       = 2;
   localparam int WORDS_PER_LINE = 8;
   localparam int NUM_SETS       = 128;

   // address split: tag | index | word offset | byte offset
   localparam int BYTE_OFF_W = 2;
   localparam int OFFSET_W   = 3;
   localparam int INDEX_W    = 7;
   localparam int TAG_W      = 20;

   // line base has the low offset bits cleared
   localparam int LINE_OFF_W = OFFSET_W + BYTE_OFF_W;

   ////////////////////
   // data and address types
   ////////////////////

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;

   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] woff_t;

   // per-byte write enables of one word
   typedef logic [3:0] be_t;

   // one bit per way, one-hot where a single way is meant
   typedef logic [NUM_WAYS-1:0] way_vec_t;

   // offset of the final beat in a burst
   localparam woff_t LAST_BEAT = woff_t'(WORDS_PER_LINE - 1);

   ////////////////////
   // controller states
   ////////////////////

   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      WB_ADDR = 3'd1,   // write-back address phase
      WB_DATA = 3'd2,   // write-back data beats
      WB_RESP = 3'd3,   // waiting for write response
      RF_ADDR = 3'd4,   // refill address phase
      RF_DATA = 3'd5,   // refill data beats
      INSTALL = 3'd6    // tag/valid update of the refilled way
   } cache_state_e;

endpackage

//--- dcache_read_mux.sv
`timescale 1ns/1ps

module dcache_read_mux
   import dcache_pkg::*;
(
   input  way_vec_t i_way_hit,
   input  word_t    i_way_word [NUM_WAYS],
   input  way_vec_t i_way_dirty,
   input  tag_t     i_way_tag  [NUM_WAYS],
   input  way_vec_t i_victim,
   output logic     o_hit,
   output way_vec_t o_hit_way,
   output word_t    o_rdata,
   output logic     o_victim_dirty,
   output tag_t     o_victim_tag,
   output word_t    o_wdata
);

   ////////////////////
   // hit side
   ////////////////////

   assign o_hit     = |i_way_hit;
   assign o_hit_way = i_way_hit;

   // and-or select, the hit vector is one-hot or zero
   always_comb begin
      o_rdata = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         o_rdata = o_rdata | (i_way_word[w] & {32{i_way_hit[w]}});
      end
   end

   ////////////////////
   // victim side
   ////////////////////

   // victim is always exactly one way
   always_comb begin
      o_wdata        = '0;
      o_victim_tag   = '0;
      o_victim_dirty = 1'b0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         o_wdata        = o_wdata | (i_way_word[w] & {32{i_victim[w]}});
         o_victim_tag   = o_victim_tag | (i_way_tag[w] & {TAG_W{i_victim[w]}});
         o_victim_dirty = o_victim_dirty | (i_way_dirty[w] & i_victim[w]);
      end
   end

   // a line lives in at most one way of its set
   always_comb begin
      a_hit_onehot : assert final ($onehot0(i_way_hit))
         else $error("more than one way hit: %b", i_way_hit);
   end

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top
   import dcache_pkg::*;
(
   input  logic  clk,
   input  logic  reset,

   // processor side
   input  logic  i_read,
   input  logic  i_write,
   input  addr_t i_addr,
   input  be_t   i_be,
   input  word_t i_wdata,
   output word_t o_rdata,
   output logic  o_stall,

   // memory read channel
   output addr_t o_araddr,
   output logic  o_arvalid,
   input  logic  i_arready,
   input  word_t i_rdata,
   input  logic  i_rvalid,
   input  logic  i_rlast,

   // memory write channel
   output addr_t o_awaddr,
   output logic  o_awvalid,
   input  logic  i_awready,
   output word_t o_wdata,
   output logic  o_wvalid,
   input  logic  i_wready,
   output logic  o_wlast,
   input  logic  i_bvalid
);

   // shared way controls
   index_t   way_index;
   tag_t     way_tag_in;
   woff_t    way_woff;
   word_t    way_wdata;
   be_t      way_be [NUM_WAYS];
   way_vec_t way_install;
   way_vec_t way_mark_dirty;

   // per-way lookup results
   way_vec_t way_hit;
   way_vec_t way_dirty;
   tag_t     way_tag [NUM_WAYS];
   word_t    way_word [NUM_WAYS];

   // merged results back to the controller
   logic     hit;
   way_vec_t hit_way;
   way_vec_t victim;
   logic     victim_dirty;
   tag_t     victim_tag;

   dcache_ctrl ctrl_i (
      .clk            (clk),
      .reset          (reset),
      .i_read         (i_read),
      .i_write        (i_write),
      .i_addr         (i_addr),
      .i_be           (i_be),
      .i_wdata        (i_wdata),
      .i_hit          (hit),
      .i_hit_way      (hit_way),
      .i_victim_dirty (victim_dirty),
      .i_victim_tag   (victim_tag),
      .i_arready      (i_arready),
      .i_rdata        (i_rdata),
      .i_rvalid       (i_rvalid),
      .i_rlast        (i_rlast),
      .i_awready      (i_awready),
      .i_wready       (i_wready),
      .i_bvalid       (i_bvalid),
      .o_stall        (o_stall),
      .o_index        (way_index),
      .o_tag          (way_tag_in),
      .o_woff         (way_woff),
      .o_way_wdata    (way_wdata),
      .o_way_be       (way_be),
      .o_install      (way_install),
      .o_mark_dirty   (way_mark_dirty),
      .o_victim       (victim),
      .o_araddr       (o_araddr),
      .o_arvalid      (o_arvalid),
      .o_awaddr       (o_awaddr),
      .o_awvalid      (o_awvalid),
      .o_wvalid       (o_wvalid),
      .o_wlast        (o_wlast)
   );

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      dcache_way way_i (
         .clk          (clk),
         .reset        (reset),
         .i_index      (way_index),
         .i_tag        (way_tag_in),
         .i_woff       (way_woff),
         .i_wdata      (way_wdata),
         .i_be         (way_be[w]),
         .i_install    (way_install[w]),
         .i_mark_dirty (way_mark_dirty[w]),
         .o_hit        (way_hit[w]),
         .o_dirty      (way_dirty[w]),
         .o_tag        (way_tag[w]),
         .o_word       (way_word[w])
      );
   end

   dcache_read_mux read_mux_i (
      .i_way_hit      (way_hit),
      .i_way_word     (way_word),
      .i_way_dirty    (way_dirty),
      .i_way_tag      (way_tag),
      .i_victim       (victim),
      .o_hit          (hit),
      .o_hit_way      (hit_way),
      .o_rdata        (o_rdata),
      .o_victim_dirty (victim_dirty),
      .o_victim_tag   (victim_tag),
      .o_wdata        (o_wdata)
   );

endmodule

//--- dcache_way.sv
`timescale 1ns/1ps

module dcache_way
   import dcache_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  index_t i_index,
   input  tag_t   i_tag,
   input  woff_t  i_woff,
   input  word_t  i_wdata,
   input  be_t    i_be,
   input  logic   i_install,
   input  logic   i_mark_dirty,
   output logic   o_hit,
   output logic   o_dirty,
   output tag_t   o_tag,
   output word_t  o_word
);

   ////////////////////
   // storage
   ////////////////////

   tag_t                tag_mem [NUM_SETS];
   logic [NUM_SETS-1:0] valid_r;
   logic [NUM_SETS-1:0] dirty_r;
   word_t               data_mem [NUM_SETS][WORDS_PER_LINE];

   // line status bits
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_r <= '0;
         dirty_r <= '0;
      end else begin
         if (i_install) begin
            valid_r[i_index] <= 1'b1;
            dirty_r[i_index] <= 1'b0;
         end else if (i_mark_dirty) begin
            dirty_r[i_index] <= 1'b1;
         end
      end
   end

   // new tag only on install
   always_ff @(posedge clk) begin
      if (i_install) begin
         tag_mem[i_index] <= i_tag;
      end
   end

   // byte writes into the addressed word
   // refill beats come in with all four enables set
   always_ff @(posedge clk) begin
      for (int b = 0; b < 4; b++) begin
         if (i_be[b]) begin
            data_mem[i_index][i_woff][b*8 +: 8] <= i_wdata[b*8 +: 8];
         end
      end
   end

   ////////////////////
   // lookup
   ////////////////////

   // combinational read of the selected set and word
   assign o_tag  = tag_mem[i_index];
   assign o_word = data_mem[i_index][i_woff];

   assign o_hit   = valid_r[i_index] && (tag_mem[i_index] == i_tag);
   assign o_dirty = valid_r[i_index] && dirty_r[i_index];

   // install comes only after a refill, a store only on a hit in idle
   a_install_vs_dirty : assert property (
      @(posedge clk) disable iff (reset)
      !(i_install && i_mark_dirty)
   ) else $error("way got install and mark-dirty in the same cycle");

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
   import dcache_pkg::*;
();

   localparam int NUM_OPS        = 22;
   localparam int OP_CYCLE_BOUND = 150;
   localparam int CYCLE_LIMIT    = (NUM_OPS + 2) * OP_CYCLE_BOUND;

   typedef struct packed {
      logic  wr;
      addr_t addr;
      be_t   be;
      word_t data;
      logic  exp_rf;
      logic  exp_wb;
      addr_t wb_line;
   } op_t;

   op_t        ops [NUM_OPS];
   logic [7:0] shadow [0:65535];
   int         cycles = 0;

   logic  clk = 1'b0;
   logic  reset;
   logic  cpu_read;
   logic  cpu_write;
   addr_t cpu_addr;
   be_t   cpu_be;
   word_t cpu_wdata;
   word_t rdata;
   logic  stall;

   addr_t araddr;
   logic  arvalid;
   logic  arready;
   word_t bus_rdata;
   logic  rvalid;
   logic  rlast;
   addr_t awaddr;
   logic  awvalid;
   logic  awready;
   word_t wdata;
   logic  wvalid;
   logic  wready;
   logic  wlast;
   logic  bvalid;

   int    ar_count;
   int    aw_count;
   int    wbeats;
   addr_t last_araddr;
   addr_t last_awaddr;

   always #10 clk = ~clk;

   dcache_top dut_i (
      .clk (clk), .reset (reset),
      .i_read (cpu_read), .i_write (cpu_write), .i_addr (cpu_addr),
      .i_be (cpu_be), .i_wdata (cpu_wdata), .o_rdata (rdata), .o_stall (stall),
      .o_araddr (araddr), .o_arvalid (arvalid), .i_arready (arready),
      .i_rdata (bus_rdata), .i_rvalid (rvalid), .i_rlast (rlast),
      .o_awaddr (awaddr), .o_awvalid (awvalid), .i_awready (awready),
      .o_wdata (wdata), .o_wvalid (wvalid), .i_wready (wready),
      .o_wlast (wlast), .i_bvalid (bvalid)
   );

   tb_mem_model mem_i (
      .clk (clk), .reset (reset),
      .i_araddr (araddr), .i_arvalid (arvalid), .o_arready (arready),
      .o_rdata (bus_rdata), .o_rvalid (rvalid), .o_rlast (rlast),
      .i_awaddr (awaddr), .i_awvalid (awvalid), .o_awready (awready),
      .i_wdata (wdata), .i_wvalid (wvalid), .o_wready (wready),
      .i_wlast (wlast), .o_bvalid (bvalid),
      .o_ar_count (ar_count), .o_aw_count (aw_count),
      .o_last_araddr (last_araddr), .o_last_awaddr (last_awaddr), .o_wbeats (wbeats)
   );

   // bound on the whole run
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("** FAIL **");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic compare_val(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %s: got %h, expected %h", name, got, exp);
         $display("** FAIL **");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // little endian with byte lane b at address a + b
   function automatic word_t shadow_word(input addr_t a);
      return {shadow[a[15:0] + 3], shadow[a[15:0] + 2], shadow[a[15:0] + 1], shadow[a[15:0]]};
   endfunction

   function automatic word_t image_word(input addr_t a);
      return {mem_i.mem[a[15:0] + 3], mem_i.mem[a[15:0] + 2],
              mem_i.mem[a[15:0] + 1], mem_i.mem[a[15:0]]};
   endfunction

   task automatic fill_images();
      logic [7:0] b;
      for (int a = 0; a < 65536; a++) begin
         b = 8'($urandom);
         shadow[a] = b;
         mem_i.mem[a] = b;
      end
   endtask

   task automatic set_op(input int n, input logic wr, input addr_t a, input be_t be,
                         input word_t d, input logic rf, input logic wb, input addr_t wl);
      ops[n] = '{wr, a, be, d, rf, wb, wl};
   endtask

   ////////////////////
   // stimulus table
   ////////////////////

   // set 3 holds lines A 0x1060, B 0x2060, C 0x3060
   task automatic load_table();
      set_op(0,  0, 32'h1064, 4'hf, 32'h0, 1, 0, 32'h0);
      set_op(1,  0, 32'h1078, 4'hf, 32'h0, 0, 0, 32'h0);
      set_op(2,  1, 32'h1068, 4'hf, 32'hdead_beef, 0, 0, 32'h0);
      set_op(3,  0, 32'h1068, 4'hf, 32'h0, 0, 0, 32'h0);
      set_op(4,  1, 32'h106c, 4'h5, 32'h1234_5678, 0, 0, 32'h0);
      set_op(5,  0, 32'h106c, 4'hf, 32'h0, 0, 0, 32'h0);
      set_op(6,  0, 32'h2060, 4'hf, 32'h0, 1, 0, 32'h0);
      set_op(7,  0, 32'h1060, 4'hf, 32'h0, 0, 0, 32'h0);
      // C replaces B and A stays
      set_op(8,  0, 32'h3064, 4'hf, 32'h0, 1, 0, 32'h0);
      set_op(9,  0, 32'h1070, 4'hf, 32'h0, 0, 0, 32'h0);
      set_op(10, 0, 32'h2064, 4'hf, 32'h0, 1, 0, 32'h0);
      // dirty A goes out to memory
      set_op(11, 0, 32'h3060, 4'hf, 32'h0, 1, 1, 32'h1060);
      set_op(12, 0, 32'h1068, 4'hf, 32'h0, 1, 0, 32'h0);
      set_op(13, 0, 32'h106c, 4'hf, 32'h0, 0, 0, 32'h0);
      // write misses allocate in set 32
      set_op(14, 1, 32'h4404, 4'hc, 32'ha5a5_5a5a, 1, 0, 32'h0);
      set_op(15, 0, 32'h4404, 4'hf, 32'h0, 0, 0, 32'h0);
      set_op(16, 1, 32'h5404, 4'hf, 32'h0bad_f00d, 1, 0, 32'h0);
      set_op(17, 0, 32'h6400, 4'hf, 32'h0, 1, 1, 32'h4400);
      set_op(18, 0, 32'h4404, 4'hf, 32'h0, 1, 1, 32'h5400);
      set_op(19, 0, 32'h5408, 4'hf, 32'h0, 1, 0, 32'h0);
      set_op(20, 0, 32'h0000, 4'hf, 32'h0, 1, 0, 32'h0);
      set_op(21, 0, 32'h001c, 4'hf, 32'h0, 0, 0, 32'h0);
   endtask

   task automatic run_op(input int n);
      op_t   op;
      int    ar_before;
      int    aw_before;
      int    waited;
      word_t got;
      op = ops[n];
      @(negedge clk);
      ar_before = ar_count;
      aw_before = aw_count;
      cpu_read  = !op.wr;
      cpu_write = op.wr;
      cpu_addr  = op.addr;
      cpu_be    = op.be;
      cpu_wdata = op.data;
      // request completes at the edge where stall is low
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
      end while (stall);
      got = rdata;
      @(negedge clk);
      cpu_read  = 1'b0;
      cpu_write = 1'b0;
      if (op.wr) begin
         for (int b = 0; b < 4; b++) begin
            if (op.be[b]) begin
               shadow[op.addr[15:0] + b] = op.data[b*8 +: 8];
            end
         end
      end else begin
         compare_val("o_rdata", got, shadow_word(op.addr));
      end
      compare_val("read burst count", ar_count - ar_before, op.exp_rf);
      if (op.exp_rf) begin
         compare_val("o_araddr", last_araddr, {op.addr[31:5], 5'b0});
      end else begin
         compare_val("hit cycles", waited, 1);
      end
      compare_val("write burst count", aw_count - aw_before, op.exp_wb);
      if (op.exp_wb) begin
         compare_val("o_awaddr", last_awaddr, op.wb_line);
         compare_val("write beats", wbeats, 8);
         for (int w = 0; w < 8; w++) begin
            compare_val("o_wdata", image_word(op.wb_line + w*4), shadow_word(op.wb_line + w*4));
         end
      end
   endtask

   initial begin
      reset     = 1'b1;
      cpu_read  = 1'b0;
      cpu_write = 1'b0;
      cpu_addr  = '0;
      cpu_be    = '0;
      cpu_wdata = '0;
      void'($urandom(32'h91df));
      fill_images();
      load_table();
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // quiet bus and no stall without a request
      repeat (4) begin
         @(posedge clk);
         compare_val("o_stall", stall, 0);
         compare_val("o_arvalid", arvalid, 0);
         compare_val("o_awvalid", awvalid, 0);
      end
      compare_val("read burst count", ar_count, 0);

      for (int n = 0; n < NUM_OPS; n++) begin
         run_op(n);
      end
      $display("** PASS **");
      $finish;
   end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
   input  logic        clk,
   input  logic        reset,
   input  logic [31:0] i_araddr,
   input  logic        i_arvalid,
   output logic        o_arready,
   output logic [31:0] o_rdata,
   output logic        o_rvalid,
   output logic        o_rlast,
   input  logic [31:0] i_awaddr,
   input  logic        i_awvalid,
   output logic        o_awready,
   input  logic [31:0] i_wdata,
   input  logic        i_wvalid,
   output logic        o_wready,
   input  logic        i_wlast,
   output logic        o_bvalid,
   output int          o_ar_count,
   output int          o_aw_count,
   output logic [31:0] o_last_araddr,
   output logic [31:0] o_last_awaddr,
   output int          o_wbeats
);

   // 64 KiB byte image, loaded by the testbench at time zero
   logic [7:0] mem [0:65535];

   logic        rd_active;
   logic [15:0] rd_base;
   int          rd_beat;
   logic        wr_active;
   logic [15:0] wr_base;
   int          wr_beat;
   logic        b_pending;

   initial begin
      o_arready = 1'b0;
      o_rdata   = '0;
      o_rvalid  = 1'b0;
      o_rlast   = 1'b0;
      o_awready = 1'b0;
      o_wready  = 1'b0;
      o_bvalid  = 1'b0;
   end

   ////////////////////
   // handshakes at the rising edge
   ////////////////////

   always @(posedge clk) begin
      if (reset) begin
         rd_active     <= 1'b0;
         rd_beat       <= 0;
         wr_active     <= 1'b0;
         wr_beat       <= 0;
         b_pending     <= 1'b0;
         o_ar_count    <= 0;
         o_aw_count    <= 0;
         o_wbeats      <= 0;
         o_last_araddr <= '0;
         o_last_awaddr <= '0;
      end else begin
         if (i_arvalid && o_arready) begin
            rd_active     <= 1'b1;
            rd_base       <= i_araddr[15:0];
            rd_beat       <= 0;
            o_ar_count    <= o_ar_count + 1;
            o_last_araddr <= i_araddr;
         end
         // rready is always high, every valid beat is taken
         if (o_rvalid) begin
            rd_beat <= rd_beat + 1;
            if (o_rlast) begin
               rd_active <= 1'b0;
            end
         end
         if (i_awvalid && o_awready) begin
            wr_active     <= 1'b1;
            wr_base       <= i_awaddr[15:0];
            wr_beat       <= 0;
            o_aw_count    <= o_aw_count + 1;
            o_last_awaddr <= i_awaddr;
         end
         if (i_wvalid && o_wready) begin
            for (int b = 0; b < 4; b++) begin
               mem[wr_base + wr_beat*4 + b] <= i_wdata[b*8 +: 8];
            end
            wr_beat <= wr_beat + 1;
            if (i_wlast) begin
               wr_active <= 1'b0;
               b_pending <= 1'b1;
               o_wbeats  <= wr_beat + 1;
            end
         end
         if (o_bvalid) begin
            b_pending <= 1'b0;
         end
      end
   end

   ////////////////////
   // responses at the falling edge
   ////////////////////

   // ready and valid high about three cycles in four
   always @(negedge clk) begin
      if (reset) begin
         o_arready <= 1'b0;
         o_rvalid  <= 1'b0;
         o_rlast   <= 1'b0;
         o_awready <= 1'b0;
         o_wready  <= 1'b0;
         o_bvalid  <= 1'b0;
      end else begin
         o_arready <= !rd_active && (($urandom % 4) != 0);
         o_rvalid  <= rd_active && (($urandom % 4) != 0);
         o_rlast   <= (rd_beat == 7);
         o_rdata   <= {mem[rd_base + rd_beat*4 + 3], mem[rd_base + rd_beat*4 + 2],
                       mem[rd_base + rd_beat*4 + 1], mem[rd_base + rd_beat*4]};
         o_awready <= !wr_active && !b_pending && (($urandom % 4) != 0);
         o_wready  <= wr_active && (($urandom % 4) != 0);
         o_bvalid  <= b_pending && (($urandom % 4) != 0);
      end
   end

endmodule
